// File: files.f
source/clint_pkg.sv
source/clint_bus_ctrl.sv
source/clint_mtime.sv
source/clint_cmp_bank.sv
source/clint_msip_bank.sv
source/clint_top.sv
test/clint_sva.sv
test/clint_tb.sv

// File: source/clint_bus_ctrl.sv
// clint bus controller: single-beat AXI slave handshakes, address decode and read data mux
`timescale 1ns/1ps

module clint_bus_ctrl #(
  parameter int unsigned NUM_HARTS = 2
) (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          aw_valid_i,
  input  clint_pkg::axi_aw_t                            aw_i,
  output logic                                          aw_ready_o,
  input  logic                                          w_valid_i,
  input  clint_pkg::axi_w_t                             w_i,
  output logic                                          w_ready_o,
  output logic                                          b_valid_o,
  output clint_pkg::axi_b_t                             b_o,
  input  logic                                          b_ready_i,
  input  logic                                          ar_valid_i,
  input  clint_pkg::axi_ar_t                            ar_i,
  output logic                                          ar_ready_o,
  output logic                                          r_valid_o,
  output clint_pkg::axi_r_t                             r_o,
  input  logic                                          r_ready_i,
  output clint_pkg::reg_wr_t                            wr_cmd_o,
  input  logic [clint_pkg::DATA_W-1:0]                  mtime_i,
  input  logic [NUM_HARTS-1:0][clint_pkg::DATA_W-1:0]   mtimecmp_i,
  input  logic [NUM_HARTS-1:0][31:0]                    msip_i
);
  import clint_pkg::*;

  typedef struct packed {
    clint_sel_e            sel;
    logic [HART_IDX_W-1:0] hart;
  } dec_t;

  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_e;
  typedef enum logic {R_IDLE, R_RESP} r_state_e;

  w_state_e w_state_q;
  w_state_e w_state_d;
  r_state_e r_state_q;
  r_state_e r_state_d;
  logic     aw_hs;
  logic     w_hs;
  logic     b_hs;
  logic     ar_hs;
  logic     r_hs;
  dec_t     aw_dec;
  dec_t     ar_dec;
  dec_t     wr_dec_q;

  // gaps, misaligned offsets and harts past NUM_HARTS give SEL_NONE
  function automatic dec_t decode(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    dec_t              dec;
    off      = addr - CLINT_BASE;
    dec.sel  = SEL_NONE;
    dec.hart = '0;
    if (addr >= CLINT_BASE) begin
      if (off >= MSIP_OFFSET && off < MSIP_OFFSET + ADDR_W'(4 * NUM_HARTS) &&
          off[1:0] == 2'b00) begin
        dec.sel  = SEL_MSIP;
        dec.hart = HART_IDX_W'((off - MSIP_OFFSET) >> 2);
      end else if (off >= MTIMECMP_OFFSET &&
                   off < MTIMECMP_OFFSET + ADDR_W'(8 * NUM_HARTS) &&
                   off[2:0] == 3'b000) begin
        dec.sel  = SEL_MTIMECMP;
        dec.hart = HART_IDX_W'((off - MTIMECMP_OFFSET) >> 3);
      end else if (off == MTIME_OFFSET) begin
        dec.sel = SEL_MTIME;
      end
    end
    return dec;
  endfunction

  function automatic logic [DATA_W-1:0] rd_value(input dec_t dec);
    logic [DATA_W-1:0] val;
    case (dec.sel)
      SEL_MSIP:     val = {32'b0, msip_i[dec.hart]};
      SEL_MTIMECMP: val = mtimecmp_i[dec.hart];
      SEL_MTIME:    val = mtime_i;
      default:      val = '0;
    endcase
    return val;
  endfunction

  function automatic logic [1:0] resp_of(input dec_t dec);
    return (dec.sel == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  assign aw_hs = aw_valid_i & aw_ready_o;
  assign w_hs  = w_valid_i & w_ready_o;
  assign b_hs  = b_valid_o & b_ready_i;
  assign ar_hs = ar_valid_i & ar_ready_o;
  assign r_hs  = r_valid_o & r_ready_i;

  assign aw_dec = decode(aw_i.addr);
  assign ar_dec = decode(ar_i.addr);

  always_comb begin
    w_state_d = w_state_q;
    case (w_state_q)
      W_IDLE:  if (aw_hs) w_state_d = W_DATA;
      W_DATA:  if (w_hs) w_state_d = W_RESP;
      W_RESP:  if (b_hs) w_state_d = W_IDLE;
      default: w_state_d = W_IDLE;
    endcase
  end

  always_comb begin
    r_state_d = r_state_q;
    case (r_state_q)
      R_IDLE:  if (ar_hs) r_state_d = R_RESP;
      R_RESP:  if (r_hs) r_state_d = R_IDLE;
      default: r_state_d = R_IDLE;
    endcase
  end

  // handshake outputs are registered from the next state
  always_ff @(posedge clk) begin
    if (rst) begin
      w_state_q  <= W_IDLE;
      r_state_q  <= R_IDLE;
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
    end else begin
      w_state_q  <= w_state_d;
      r_state_q  <= r_state_d;
      aw_ready_o <= (w_state_d == W_IDLE);
      w_ready_o  <= (w_state_d == W_DATA);
      b_valid_o  <= (w_state_d == W_RESP);
      ar_ready_o <= (r_state_d == R_IDLE);
      r_valid_o  <= (r_state_d == R_RESP);
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_dec_q <= aw_dec;
      b_o.id   <= aw_i.id;
      b_o.resp <= resp_of(aw_dec);
    end
    // read value captured at the address handshake
    if (ar_hs) begin
      r_o.id   <= ar_i.id;
      r_o.data <= rd_value(ar_dec);
      r_o.resp <= resp_of(ar_dec);
    end
  end

  assign wr_cmd_o.en   = w_hs;
  assign wr_cmd_o.sel  = wr_dec_q.sel;
  assign wr_cmd_o.hart = wr_dec_q.hart;
  assign wr_cmd_o.data = w_i.data;
  assign wr_cmd_o.strb = w_i.strb;

endmodule

// File: source/clint_cmp_bank.sv
// clint mtimecmp bank: per-hart compare registers and registered timer interrupts
`timescale 1ns/1ps

module clint_cmp_bank #(
  parameter int unsigned NUM_HARTS = 2
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  clint_pkg::reg_wr_t                          wr_cmd_i,
  input  logic [clint_pkg::DATA_W-1:0]                mtime_i,
  output logic [NUM_HARTS-1:0][clint_pkg::DATA_W-1:0] mtimecmp_o,
  output logic [NUM_HARTS-1:0]                        mtip_irq_o
);
  import clint_pkg::*;

  logic [NUM_HARTS-1:0][DATA_W-1:0] mtimecmp_q;
  logic [NUM_HARTS-1:0]             hit;
  logic [DATA_W-1:0]                wr_mask;

  assign wr_mask = strb_mask(wr_cmd_i.strb);

  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      hit[h] = wr_cmd_i.en && (wr_cmd_i.sel == SEL_MTIMECMP) &&
               (wr_cmd_i.hart == HART_IDX_W'(h));
    end
  end

  // all ones keeps the timer interrupt quiet out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= '1;
      mtip_irq_o <= '0;
    end else begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (hit[h]) begin
          mtimecmp_q[h] <= (mtimecmp_q[h] & ~wr_mask) | (wr_cmd_i.data & wr_mask);
        end
        // compare against the value held this cycle
        mtip_irq_o[h] <= (mtime_i >= mtimecmp_q[h]);
      end
    end
  end

  assign mtimecmp_o = mtimecmp_q;

endmodule

// File: source/clint_msip_bank.sv
// clint msip bank: per-hart software interrupt registers with byte strobes
`timescale 1ns/1ps

module clint_msip_bank #(
  parameter int unsigned NUM_HARTS = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  clint_pkg::reg_wr_t         wr_cmd_i,
  output logic [NUM_HARTS-1:0][31:0] msip_o,
  output logic [NUM_HARTS-1:0]       msip_irq_o
);
  import clint_pkg::*;

  logic [NUM_HARTS-1:0][31:0] msip_q;
  logic [NUM_HARTS-1:0]       hit;
  logic [DATA_W-1:0]          wr_mask;

  // only the low word of the bus is kept
  assign wr_mask = strb_mask(wr_cmd_i.strb);

  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      hit[h] = wr_cmd_i.en && (wr_cmd_i.sel == SEL_MSIP) &&
               (wr_cmd_i.hart == HART_IDX_W'(h));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= '0;
    end else begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (hit[h]) begin
          msip_q[h] <= (msip_q[h] & ~wr_mask[31:0]) | (wr_cmd_i.data[31:0] & wr_mask[31:0]);
        end
      end
    end
  end

  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      msip_irq_o[h] = msip_q[h][0];
    end
  end

  assign msip_o = msip_q;

endmodule

// File: source/clint_mtime.sv
// clint mtime: shared free-running timer with byte-strobed loads
`timescale 1ns/1ps

module clint_mtime #(
  parameter int unsigned MTIME_STEP = 1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  clint_pkg::reg_wr_t           wr_cmd_i,
  output logic [clint_pkg::DATA_W-1:0] mtime_o
);
  import clint_pkg::*;

  logic [DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0] wr_mask;
  logic              load;

  assign load    = wr_cmd_i.en && (wr_cmd_i.sel == SEL_MTIME);
  assign wr_mask = strb_mask(wr_cmd_i.strb);

  // a load replaces the step for that cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (load) begin
      mtime_q <= (mtime_q & ~wr_mask) | (wr_cmd_i.data & wr_mask);
    end else begin
      mtime_q <= mtime_q + DATA_W'(MTIME_STEP);
    end
  end

  assign mtime_o = mtime_q;

endmodule

// File: source/clint_pkg.sv
// clint package: bus channel structs, register write command, select codes and address map
package clint_pkg;

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned ID_W       = 4;
  localparam int unsigned MAX_HARTS  = 16;
  localparam int unsigned HART_IDX_W = 4;

  // standard clint layout
  localparam logic [ADDR_W-1:0] CLINT_BASE      = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] MSIP_OFFSET     = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] MTIMECMP_OFFSET = 32'h0000_4000;
  localparam logic [ADDR_W-1:0] MTIME_OFFSET    = 32'h0000_bff8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    SEL_NONE     = 2'd0,
    SEL_MSIP     = 2'd1,
    SEL_MTIMECMP = 2'd2,
    SEL_MTIME    = 2'd3
  } clint_sel_e;

  // address channels, shared by aw and ar
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axi_r_t;

  // one-cycle write pulse from controller to the register blocks
  typedef struct packed {
    logic                  en;
    clint_sel_e            sel;
    logic [HART_IDX_W-1:0] hart;
    logic [DATA_W-1:0]     data;
    logic [DATA_W/8-1:0]   strb;
  } reg_wr_t;

  // byte strobes expanded to a bit mask
  function automatic logic [DATA_W-1:0] strb_mask(input logic [DATA_W/8-1:0] strb);
    logic [DATA_W-1:0] mask;
    for (int i = 0; i < DATA_W / 8; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage

// File: source/clint_top.sv
// clint top: AXI slave controller joined to the mtime, mtimecmp and msip blocks
`timescale 1ns/1ps

module clint_top #(
  parameter int unsigned NUM_HARTS  = 2,
  parameter int unsigned MTIME_STEP = 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 aw_valid_i,
  input  clint_pkg::axi_aw_t   aw_i,
  output logic                 aw_ready_o,
  input  logic                 w_valid_i,
  input  clint_pkg::axi_w_t    w_i,
  output logic                 w_ready_o,
  output logic                 b_valid_o,
  output clint_pkg::axi_b_t    b_o,
  input  logic                 b_ready_i,
  input  logic                 ar_valid_i,
  input  clint_pkg::axi_ar_t   ar_i,
  output logic                 ar_ready_o,
  output logic                 r_valid_o,
  output clint_pkg::axi_r_t    r_o,
  input  logic                 r_ready_i,
  output logic [NUM_HARTS-1:0] msip_irq_o,
  output logic [NUM_HARTS-1:0] mtip_irq_o
);
  import clint_pkg::*;

  reg_wr_t                          wr_cmd;
  logic [DATA_W-1:0]                mtime;
  logic [NUM_HARTS-1:0][DATA_W-1:0] mtimecmp;
  logic [NUM_HARTS-1:0][31:0]       msip;

  // hart count must fit the decoder's index width
  if (NUM_HARTS < 1 || NUM_HARTS > MAX_HARTS) begin : g_hart_check
    $error("clint_top: NUM_HARTS out of range");
  end

  clint_bus_ctrl #(
    .NUM_HARTS (NUM_HARTS)
  ) i_bus_ctrl (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_i       (aw_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_i        (w_i),
    .w_ready_o  (w_ready_o),
    .b_valid_o  (b_valid_o),
    .b_o        (b_o),
    .b_ready_i  (b_ready_i),
    .ar_valid_i (ar_valid_i),
    .ar_i       (ar_i),
    .ar_ready_o (ar_ready_o),
    .r_valid_o  (r_valid_o),
    .r_o        (r_o),
    .r_ready_i  (r_ready_i),
    .wr_cmd_o   (wr_cmd),
    .mtime_i    (mtime),
    .mtimecmp_i (mtimecmp),
    .msip_i     (msip)
  );

  clint_mtime #(
    .MTIME_STEP (MTIME_STEP)
  ) i_mtime (
    .clk      (clk),
    .rst      (rst),
    .wr_cmd_i (wr_cmd),
    .mtime_o  (mtime)
  );

  clint_cmp_bank #(
    .NUM_HARTS (NUM_HARTS)
  ) i_cmp_bank (
    .clk        (clk),
    .rst        (rst),
    .wr_cmd_i   (wr_cmd),
    .mtime_i    (mtime),
    .mtimecmp_o (mtimecmp),
    .mtip_irq_o (mtip_irq_o)
  );

  clint_msip_bank #(
    .NUM_HARTS (NUM_HARTS)
  ) i_msip_bank (
    .clk        (clk),
    .rst        (rst),
    .wr_cmd_i   (wr_cmd),
    .msip_o     (msip),
    .msip_irq_o (msip_irq_o)
  );

endmodule

// File: test/clint_sva.sv
// clint assertions: response handshake stability, aw/b exclusion and registered timer interrupts
`timescale 1ns/1ps

module clint_sva #(
  parameter int unsigned NUM_HARTS = 2
) (
  input logic                                        clk,
  input logic                                        rst,
  input logic                                        aw_ready_i,
  input logic                                        b_valid_i,
  input clint_pkg::axi_b_t                           b_i,
  input logic                                        b_ready_i,
  input logic                                        r_valid_i,
  input clint_pkg::axi_r_t                           r_i,
  input logic                                        r_ready_i,
  input logic [NUM_HARTS-1:0]                        mtip_irq_i,
  input logic [clint_pkg::DATA_W-1:0]                mtime_i,
  input logic [NUM_HARTS-1:0][clint_pkg::DATA_W-1:0] mtimecmp_i
);
  import clint_pkg::*;

  logic [NUM_HARTS-1:0] cmp_now;
  int unsigned          fail_cnt = 0;

  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      cmp_now[h] = (mtime_i >= mtimecmp_i[h]);
    end
  end

  b_valid_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid_i && !b_ready_i |=> b_valid_i)
    else begin
      fail_cnt++;
      $error("b valid dropped before b ready");
    end

  r_valid_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_i && !r_ready_i |=> r_valid_i)
    else begin
      fail_cnt++;
      $error("r valid dropped before r ready");
    end

  b_stable: assert property (@(posedge clk) disable iff (rst)
    b_valid_i && !b_ready_i |=> $stable(b_i))
    else begin
      fail_cnt++;
      $error("b struct changed while stalled");
    end

  r_stable: assert property (@(posedge clk) disable iff (rst)
    r_valid_i && !r_ready_i |=> $stable(r_i))
    else begin
      fail_cnt++;
      $error("r struct changed while stalled");
    end

  aw_b_excl: assert property (@(posedge clk) disable iff (rst)
    !(aw_ready_i && b_valid_i))
    else begin
      fail_cnt++;
      $error("aw ready high while b valid high");
    end

  // one cycle lag of the comparison
  mtip_lag: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> mtip_irq_i == $past(cmp_now))
    else begin
      fail_cnt++;
      $error("mtip irq does not match last cycle's comparison");
    end

endmodule

// File: test/clint_tb.sv
// clint testbench: directed AXI tests of msip, mtime, mtimecmp, decode errors and back-pressure
`timescale 1ns/1ps

module clint_tb;
  import clint_pkg::*;

  localparam int unsigned NUM_HARTS  = 2;
  localparam int unsigned MTIME_STEP = 1;
  localparam int unsigned MAX_CYCLES = 3000;

  logic                 clk;
  logic                 rst;
  logic                 aw_valid;
  axi_aw_t              aw;
  logic                 aw_ready;
  logic                 w_valid;
  axi_w_t               w;
  logic                 w_ready;
  logic                 b_valid;
  axi_b_t               b;
  logic                 b_ready;
  logic                 ar_valid;
  axi_ar_t              ar;
  logic                 ar_ready;
  logic                 r_valid;
  axi_r_t               r;
  logic                 r_ready;
  logic [NUM_HARTS-1:0] msip_irq;
  logic [NUM_HARTS-1:0] mtip_irq;
  int unsigned          cycle_cnt;
  int unsigned          value_errs;
  int unsigned          other_errs;
  int unsigned          w_hs_cycle;
  int unsigned          ar_hs_cycle;
  logic [31:0]          seed;
  logic [31:0]          msip_model [NUM_HARTS];

  clint_top #(
    .NUM_HARTS  (NUM_HARTS),
    .MTIME_STEP (MTIME_STEP)
  ) i_dut (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid),
    .aw_i       (aw),
    .aw_ready_o (aw_ready),
    .w_valid_i  (w_valid),
    .w_i        (w),
    .w_ready_o  (w_ready),
    .b_valid_o  (b_valid),
    .b_o        (b),
    .b_ready_i  (b_ready),
    .ar_valid_i (ar_valid),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_o        (r),
    .r_ready_i  (r_ready),
    .msip_irq_o (msip_irq),
    .mtip_irq_o (mtip_irq)
  );

  bind clint_top clint_sva #(.NUM_HARTS(NUM_HARTS)) i_sva (
    .clk        (clk),
    .rst        (rst),
    .aw_ready_i (aw_ready_o),
    .b_valid_i  (b_valid_o),
    .b_i        (b_o),
    .b_ready_i  (b_ready_i),
    .r_valid_i  (r_valid_o),
    .r_i        (r_o),
    .r_ready_i  (r_ready_i),
    .mtip_irq_i (mtip_irq_o),
    .mtime_i    (mtime),
    .mtimecmp_i (mtimecmp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
               i_dut.i_sva.fail_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] v);
    seed = xorshift(seed);
    v = seed;
  endtask

  function automatic logic [63:0] byte_mask(input logic [7:0] strb);
    logic [63:0] m;
    for (int i = 0; i < 8; i++) begin
      m[8*i +: 8] = strb[i] ? 8'hff : 8'h00;
    end
    return m;
  endfunction

  function automatic logic [ADDR_W-1:0] msip_addr(input int h);
    return CLINT_BASE + MSIP_OFFSET + ADDR_W'(4 * h);
  endfunction

  function automatic logic [ADDR_W-1:0] mtimecmp_addr(input int h);
    return CLINT_BASE + MTIMECMP_OFFSET + ADDR_W'(8 * h);
  endfunction

  function automatic logic [NUM_HARTS-1:0] msip_bits();
    logic [NUM_HARTS-1:0] v;
    for (int h = 0; h < NUM_HARTS; h++) begin
      v[h] = msip_model[h][0];
    end
    return v;
  endfunction

  task automatic check_b(input string what, input axi_b_t got, input axi_b_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED b_o %s: got %h expected %h", what, got, exp);
    end
  endtask

  task automatic check_r(input string what, input axi_r_t got, input axi_r_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED r_o %s: got %h expected %h", what, got, exp);
    end
  endtask

  task automatic check_irq(input string what, input logic [NUM_HARTS-1:0] msip_exp,
                           input logic [NUM_HARTS-1:0] mtip_exp);
    if (msip_irq !== msip_exp) begin
      value_errs++;
      $display("CHECK FAILED msip_irq_o %s: got %h expected %h", what, msip_irq, msip_exp);
    end
    if (mtip_irq !== mtip_exp) begin
      value_errs++;
      $display("CHECK FAILED mtip_irq_o %s: got %h expected %h", what, mtip_irq, mtip_exp);
    end
  endtask

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                           input logic [DATA_W-1:0] data, input logic [7:0] strb,
                           input int unsigned stall, output axi_b_t resp);
    axi_b_t held;
    @(posedge clk);
    aw_valid <= 1'b1;
    aw       <= '{id: id, addr: addr};
    do @(negedge clk); while (!aw_ready);
    @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b1;
    w        <= '{data: data, strb: strb};
    do @(negedge clk); while (!w_ready);
    w_hs_cycle = cycle_cnt;
    @(posedge clk);
    w_valid <= 1'b0;
    do @(negedge clk); while (!b_valid);
    held = b;
    repeat (stall) begin
      @(negedge clk);
      if (!b_valid) begin
        other_errs++;
        $display("b valid dropped while b ready was held low");
      end
      check_b("stable under stall", b, held);
    end
    @(posedge clk);
    b_ready <= 1'b1;
    @(posedge clk);
    b_ready <= 1'b0;
    resp = held;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                          input int unsigned stall, output axi_r_t resp);
    axi_r_t held;
    @(posedge clk);
    ar_valid <= 1'b1;
    ar       <= '{id: id, addr: addr};
    do @(negedge clk); while (!ar_ready);
    ar_hs_cycle = cycle_cnt;
    @(posedge clk);
    ar_valid <= 1'b0;
    do @(negedge clk); while (!r_valid);
    held = r;
    repeat (stall) begin
      @(negedge clk);
      if (!r_valid) begin
        other_errs++;
        $display("r valid dropped while r ready was held low");
      end
      check_r("stable under stall", r, held);
    end
    @(posedge clk);
    r_ready <= 1'b1;
    @(posedge clk);
    r_ready <= 1'b0;
    resp = held;
  endtask

  task automatic reset_state();
    axi_r_t      got;
    logic [31:0] rnd;
    @(negedge clk);
    if (aw_ready || w_ready || b_valid || ar_ready || r_valid) begin
      other_errs++;
      $display("a ready or valid output was high in the first cycle after reset");
    end
    @(negedge clk);
    if (!aw_ready || !ar_ready) begin
      other_errs++;
      $display("aw ready or ar ready did not rise after reset");
    end
    check_irq("after reset", '0, '0);
    for (int h = 0; h < NUM_HARTS; h++) begin
      draw_random(rnd);
      axi_read(msip_addr(h), rnd[3:0], 0, got);
      check_r("msip reset value", got, '{id: rnd[3:0], data: '0, resp: RESP_OKAY});
      axi_read(mtimecmp_addr(h), rnd[7:4], 0, got);
      check_r("mtimecmp reset value", got, '{id: rnd[7:4], data: '1, resp: RESP_OKAY});
    end
  endtask

  task automatic msip_merge();
    logic [31:0] d;
    logic [31:0] s;
    logic [63:0] m;
    axi_b_t      bresp;
    axi_r_t      got;
    for (int n = 0; n < 6; n++) begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        draw_random(d);
        draw_random(s);
        // keep the strobe partial so the merge shows
        if (s[3:0] == 4'hf) s[1] = 1'b0;
        m = byte_mask(s[7:0]);
        axi_write(msip_addr(h), s[11:8], {~d, d}, s[7:0], 0, bresp);
        msip_model[h] = (msip_model[h] & ~m[31:0]) | (d & m[31:0]);
        check_b("msip write", bresp, '{id: s[11:8], resp: RESP_OKAY});
        @(negedge clk);
        check_irq("after msip write", msip_bits(), '0);
        axi_read(msip_addr(h), s[15:12], 0, got);
        check_r("msip readback", got,
                '{id: s[15:12], data: {32'b0, msip_model[h]}, resp: RESP_OKAY});
      end
    end
    for (int h = 0; h < NUM_HARTS; h++) begin
      axi_write(msip_addr(h), 4'h3, '0, 8'hff, 0, bresp);
      msip_model[h] = '0;
    end
  endtask

  task automatic mtime_count();
    logic [31:0]       hi;
    logic [31:0]       lo;
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] limit;
    axi_b_t            bresp;
    axi_r_t            got;
    axi_r_t            first;
    draw_random(hi);
    draw_random(lo);
    v = {8'h00, hi[23:0], lo};
    axi_write(CLINT_BASE + MTIME_OFFSET, hi[27:24], v, 8'hff, 0, bresp);
    check_b("mtime write", bresp, '{id: hi[27:24], resp: RESP_OKAY});
    axi_read(CLINT_BASE + MTIME_OFFSET, lo[3:0], 0, got);
    limit = v + DATA_W'(MTIME_STEP * (ar_hs_cycle - w_hs_cycle));
    if (got.data < v || got.data > limit) begin
      value_errs++;
      $display("CHECK FAILED r_o.data mtime: got %h expected %h to %h", got.data, v, limit);
    end
    // data already checked against its window
    check_r("mtime read", got, '{id: lo[3:0], data: got.data, resp: RESP_OKAY});
    first = got;
    axi_read(CLINT_BASE + MTIME_OFFSET, lo[7:4], 0, got);
    if (got.data <= first.data) begin
      value_errs++;
      $display("CHECK FAILED r_o.data mtime second read: got %h expected above %h",
               got.data, first.data);
    end
    check_irq("after mtime write", msip_bits(), '0);
  endtask

  task automatic timer_irq();
    axi_b_t      bresp;
    axi_r_t      got;
    int unsigned waited;
    axi_read(CLINT_BASE + MTIME_OFFSET, 4'h6, 0, got);
    axi_write(mtimecmp_addr(1), 4'h9, got.data + 64'd50, 8'hff, 0, bresp);
    check_b("mtimecmp write", bresp, '{id: 4'h9, resp: RESP_OKAY});
    @(negedge clk);
    check_irq("right after mtimecmp write", msip_bits(), '0);
    waited = 0;
    while (!mtip_irq[1] && waited < 60) begin
      @(negedge clk);
      waited++;
      if (mtip_irq[0]) begin
        other_errs++;
        $display("hart 0 timer interrupt rose while its mtimecmp is all ones");
      end
    end
    if (!mtip_irq[1]) begin
      other_errs++;
      $display("hart 1 timer interrupt did not rise within 60 cycles");
    end
    axi_write(mtimecmp_addr(1), 4'ha, '1, 8'hff, 0, bresp);
    check_b("mtimecmp clear", bresp, '{id: 4'ha, resp: RESP_OKAY});
    @(negedge clk);
    check_irq("after mtimecmp clear", msip_bits(), '0);
  endtask

  task automatic unmapped_access();
    logic [ADDR_W-1:0] bad_addr [6];
    logic [31:0]       rnd;
    axi_b_t            bresp;
    axi_r_t            got;
    bad_addr[0] = msip_addr(NUM_HARTS);
    bad_addr[1] = mtimecmp_addr(NUM_HARTS);
    bad_addr[2] = CLINT_BASE + 32'h0000_2000;
    bad_addr[3] = CLINT_BASE + MTIME_OFFSET - 32'd8;
    bad_addr[4] = CLINT_BASE + MTIME_OFFSET + 32'd4;
    bad_addr[5] = CLINT_BASE - 32'd4;
    for (int i = 0; i < 6; i++) begin
      draw_random(rnd);
      axi_write(bad_addr[i], rnd[3:0], {rnd, ~rnd}, 8'hff, 0, bresp);
      check_b("unmapped write", bresp, '{id: rnd[3:0], resp: RESP_SLVERR});
      axi_read(bad_addr[i], rnd[7:4], 0, got);
      check_r("unmapped read", got, '{id: rnd[7:4], data: '0, resp: RESP_SLVERR});
    end
    for (int h = 0; h < NUM_HARTS; h++) begin
      axi_read(msip_addr(h), 4'h1, 0, got);
      check_r("msip after unmapped", got,
              '{id: 4'h1, data: {32'b0, msip_model[h]}, resp: RESP_OKAY});
      axi_read(mtimecmp_addr(h), 4'h2, 0, got);
      check_r("mtimecmp after unmapped", got, '{id: 4'h2, data: '1, resp: RESP_OKAY});
    end
  endtask

  task automatic overlap_stall();
    logic [31:0]     rnd;
    logic [31:0]     d;
    logic [ID_W-1:0] wid;
    logic [ID_W-1:0] rid;
    axi_b_t          bresp;
    axi_r_t          got;
    for (int n = 0; n < 4; n++) begin
      draw_random(rnd);
      draw_random(d);
      wid = rnd[3:0];
      rid = (rnd[7:4] == wid) ? ~wid : rnd[7:4];
      // overlapping write and read with independent stalls
      fork
        axi_write(msip_addr(0), wid, {32'b0, d}, 8'h0f, 1 + rnd[10:8], bresp);
        axi_read(mtimecmp_addr(1), rid, 1 + rnd[14:12], got);
      join
      msip_model[0] = d;
      check_b("overlapped write", bresp, '{id: wid, resp: RESP_OKAY});
      check_r("overlapped read", got, '{id: rid, data: '1, resp: RESP_OKAY});
    end
    axi_read(msip_addr(0), 4'h5, 3, got);
    check_r("msip after overlap", got,
            '{id: 4'h5, data: {32'b0, msip_model[0]}, resp: RESP_OKAY});
    @(negedge clk);
    check_irq("after overlap", msip_bits(), '0);
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    aw_valid   = 1'b0;
    aw         = '0;
    w_valid    = 1'b0;
    w          = '0;
    b_ready    = 1'b0;
    ar_valid   = 1'b0;
    ar         = '0;
    r_ready    = 1'b0;
    seed       = 32'h274c;
    cycle_cnt  = 0;
    value_errs = 0;
    other_errs = 0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      msip_model[h] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    reset_state();
    msip_merge();
    mtime_count();
    timer_irq();
    unmapped_access();
    overlap_stall();
    $display("errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
             i_dut.i_sva.fail_cnt);
    if (value_errs == 0 && other_errs == 0 && i_dut.i_sva.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
